//--- verilog/rv_decode_macros.svh
// Width, reset and trap-cause constants for the RV32I decode stage
`ifndef RV_DECODE_MACROS_SVH
`define RV_DECODE_MACROS_SVH

// ---------------------------------------------------------------------------
// Datapath widths
// ---------------------------------------------------------------------------
`define RV_XLEN         32              // Data and address width
`define RV_REG_W        5               // Register address width

// ---------------------------------------------------------------------------
// Program counter
// ---------------------------------------------------------------------------
`define RV_PC_RESET     32'h8000_0000   // First fetch address
`define RV_PC_STEP      4               // Bytes per 32-bit instruction

// Trap causes, carried in the rd field of a trap record
`define RV_TRAP_IACCESS 1               // Fetch error
`define RV_TRAP_IOPCODE 2               // Invalid instruction

`endif

//--- verilog/rv_decode_pkg.sv
// Encodings and issue record types of the RV32I decode stage
`default_nettype none
`include "rv_decode_macros.svh"

package rv_decode_pkg;

    // Major opcodes, low two bits included
    typedef enum logic [6:0] {
        OP     = 7'b0110011,
        OP_IMM = 7'b0010011,
        LOAD   = 7'b0000011,
        STORE  = 7'b0100011,
        BRANCH = 7'b1100011,
        JAL    = 7'b1101111,
        JALR   = 7'b1100111,
        LUI    = 7'b0110111,
        AUIPC  = 7'b0010111
    } opcode_e;

    typedef enum logic [1:0] {FU_NONE, FU_ALU, FU_LSU, FU_CFU} fu_e;

    // ---------------------------------------------------------------------------
    // Micro-ops, one space per unit
    // ---------------------------------------------------------------------------
    typedef enum logic [4:0] {
        ALU_ADD  = 5'h00, ALU_SUB  = 5'h01, ALU_AND  = 5'h02, ALU_OR   = 5'h03,
        ALU_XOR  = 5'h04, ALU_SLT  = 5'h05, ALU_SLTU = 5'h06, ALU_SLL  = 5'h07,
        ALU_SRL  = 5'h08, ALU_SRA  = 5'h09,
        CFU_BEQ  = 5'h10, CFU_BNE  = 5'h11, CFU_BLT  = 5'h12, CFU_BGE  = 5'h13,
        CFU_BLTU = 5'h14, CFU_BGEU = 5'h15, CFU_JALI = 5'h16, CFU_JALR = 5'h17,
        LSU_LB   = 5'h18, LSU_LBU  = 5'h19, LSU_LH   = 5'h1a, LSU_LHU  = 5'h1b,
        LSU_LW   = 5'h1c, LSU_SB   = 5'h1d, LSU_SH   = 5'h1e, LSU_SW   = 5'h1f
    } uop_e;

    typedef enum logic [2:0] {IMM_NONE, IMM_I, IMM_S, IMM_B, IMM_U, IMM_J} imm_fmt_e;

    typedef enum logic [1:0] {A_ZERO, A_RS1, A_PCIMM} opra_e;
    typedef enum logic [1:0] {B_ZERO, B_RS2, B_IMM} oprb_e;
    typedef enum logic [1:0] {C_ZERO, C_RS2, C_PCIMM} oprc_e;

    typedef struct packed {
        opra_e opra;
        oprb_e oprb;
        oprc_e oprc;
    } opr_src_t;

    // Record handed to the execute stage
    typedef struct packed {
        logic [`RV_REG_W-1:0] rd;     // Destination or trap cause
        logic [`RV_XLEN-1:0]  opr_a;
        logic [`RV_XLEN-1:0]  opr_b;
        logic [`RV_XLEN-1:0]  opr_c;
        uop_e                 uop;
        fu_e                  fu;
    } issue_t;

endpackage

`default_nettype wire

//--- verilog/instr_classifier.sv
// Instruction classifier mapping RV32I words to unit, micro-op, operand sources and traps
`timescale 1ns/10ps
`default_nettype none
`include "rv_decode_macros.svh"

module instr_classifier import rv_decode_pkg::*; (
    input  wire [31:0]           instr_i,
    input  wire                  fetch_error_i,
    output logic [`RV_REG_W-1:0] rs1_addr_o,
    output logic [`RV_REG_W-1:0] rs2_addr_o,
    output logic [`RV_REG_W-1:0] rd_o,
    output fu_e                  fu_o,
    output uop_e                 uop_o,
    output imm_fmt_e             imm_fmt_o,
    output opr_src_t             opr_src_o,
    output logic                 trap_o
);

    logic [2:0] funct3;
    logic [6:0] funct7;
    logic       legal;       // Word is in the supported set
    logic       no_rd;       // Stores and branches

    assign funct3     = instr_i[14:12];
    assign funct7     = instr_i[31:25];
    assign rs1_addr_o = instr_i[19:15];
    assign rs2_addr_o = instr_i[24:20];

    // Shared by register and immediate ALU forms
    function automatic uop_e alu_op(input logic [2:0] f3, input logic alt);
        case (f3)
            3'b000:  return alt ? ALU_SUB : ALU_ADD;
            3'b001:  return ALU_SLL;
            3'b010:  return ALU_SLT;
            3'b011:  return ALU_SLTU;
            3'b100:  return ALU_XOR;
            3'b101:  return alt ? ALU_SRA : ALU_SRL;
            3'b110:  return ALU_OR;
            default: return ALU_AND;
        endcase
    endfunction

    always_comb begin
        legal     = 1'b1;
        no_rd     = 1'b0;
        fu_o      = FU_NONE;
        uop_o     = ALU_ADD;
        imm_fmt_o = IMM_NONE;
        opr_src_o = '{A_ZERO, B_ZERO, C_ZERO};
        // Compressed words miss every opcode since bits 1:0 are not 11
        case (opcode_e'(instr_i[6:0]))
            OP: begin
                fu_o      = FU_ALU;
                uop_o     = alu_op(funct3, funct7[5]);
                opr_src_o = '{A_RS1, B_RS2, C_ZERO};
                legal     = funct7 == 7'b0000000 ||
                            (funct7 == 7'b0100000 && (funct3 == 3'b000 || funct3 == 3'b101));
            end
            OP_IMM: begin
                fu_o      = FU_ALU;
                uop_o     = alu_op(funct3, funct7[5] && funct3 == 3'b101);
                imm_fmt_o = IMM_I;
                opr_src_o = '{A_RS1, B_IMM, C_ZERO};
                if (funct3 == 3'b001) begin
                    legal = funct7 == 7'b0000000;
                end else if (funct3 == 3'b101) begin
                    legal = funct7 == 7'b0000000 || funct7 == 7'b0100000;
                end
            end
            LOAD: begin
                fu_o      = FU_LSU;
                imm_fmt_o = IMM_I;
                opr_src_o = '{A_RS1, B_IMM, C_ZERO};
                case (funct3)
                    3'b000:  uop_o = LSU_LB;
                    3'b001:  uop_o = LSU_LH;
                    3'b010:  uop_o = LSU_LW;
                    3'b100:  uop_o = LSU_LBU;
                    3'b101:  uop_o = LSU_LHU;
                    default: legal = 1'b0;
                endcase
            end
            STORE: begin
                fu_o      = FU_LSU;
                imm_fmt_o = IMM_S;
                opr_src_o = '{A_RS1, B_IMM, C_RS2};   // Store data rides in C
                no_rd     = 1'b1;
                case (funct3)
                    3'b000:  uop_o = LSU_SB;
                    3'b001:  uop_o = LSU_SH;
                    3'b010:  uop_o = LSU_SW;
                    default: legal = 1'b0;
                endcase
            end
            BRANCH: begin
                fu_o      = FU_CFU;
                imm_fmt_o = IMM_B;
                opr_src_o = '{A_RS1, B_RS2, C_PCIMM};
                no_rd     = 1'b1;
                case (funct3)
                    3'b000:  uop_o = CFU_BEQ;
                    3'b001:  uop_o = CFU_BNE;
                    3'b100:  uop_o = CFU_BLT;
                    3'b101:  uop_o = CFU_BGE;
                    3'b110:  uop_o = CFU_BLTU;
                    3'b111:  uop_o = CFU_BGEU;
                    default: legal = 1'b0;
                endcase
            end
            JAL: begin
                fu_o      = FU_CFU;
                uop_o     = CFU_JALI;
                imm_fmt_o = IMM_J;
                opr_src_o = '{A_ZERO, B_ZERO, C_PCIMM};
            end
            JALR: begin
                fu_o      = FU_CFU;
                uop_o     = CFU_JALR;
                imm_fmt_o = IMM_I;
                opr_src_o = '{A_RS1, B_IMM, C_ZERO};
                legal     = funct3 == 3'b000;
            end
            LUI: begin
                fu_o      = FU_ALU;
                uop_o     = ALU_OR;                    // Zero OR immediate
                imm_fmt_o = IMM_U;
                opr_src_o = '{A_ZERO, B_IMM, C_ZERO};
            end
            AUIPC: begin
                fu_o      = FU_ALU;
                uop_o     = ALU_ADD;
                imm_fmt_o = IMM_U;
                opr_src_o = '{A_PCIMM, B_ZERO, C_ZERO};
            end
            default: legal = 1'b0;
        endcase

        trap_o = fetch_error_i || !legal;
        if (trap_o) begin
            fu_o  = FU_NONE;
            uop_o = ALU_ADD;                           // All-zero encoding
            rd_o  = legal ? `RV_REG_W'(`RV_TRAP_IACCESS) : `RV_REG_W'(`RV_TRAP_IOPCODE);
        end else if (no_rd) begin
            rd_o = '0;
        end else begin
            rd_o = instr_i[11:7];
        end
    end

endmodule

`default_nettype wire

//--- verilog/imm_extract.sv
// Immediate unit building sign-extended and PC-relative immediates
`timescale 1ns/10ps
`default_nettype none
`include "rv_decode_macros.svh"

module imm_extract import rv_decode_pkg::*; (
    input  wire [31:0]          instr_i,
    input  imm_fmt_e            imm_fmt_i,
    output logic [`RV_XLEN-1:0] imm_o,      // Immediate for operand B
    output logic [`RV_XLEN-1:0] imm_pc_o    // Immediate added to the PC
);

    always_comb begin
        case (imm_fmt_i)
            IMM_I: imm_o = {{20{instr_i[31]}}, instr_i[31:20]};
            IMM_S: imm_o = {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
            IMM_B: begin
                // Halfword offset, bit 0 implied
                imm_o = {{19{instr_i[31]}}, instr_i[31], instr_i[7],
                         instr_i[30:25], instr_i[11:8], 1'b0};
            end
            IMM_U: imm_o = {instr_i[31:12], 12'b0};
            IMM_J: begin
                imm_o = {{11{instr_i[31]}}, instr_i[31], instr_i[19:12],
                         instr_i[20], instr_i[30:21], 1'b0};
            end
            default: imm_o = '0;
        endcase
    end

    // Only branch, jump and upper-immediate forms feed the PC adder
    assign imm_pc_o = (imm_fmt_i == IMM_B || imm_fmt_i == IMM_J || imm_fmt_i == IMM_U) ?
                      imm_o : '0;

endmodule

`default_nettype wire

//--- verilog/operand_select.sv
// Operand unit holding the program counter and forming operands A, B and C
`timescale 1ns/10ps
`default_nettype none
`include "rv_decode_macros.svh"

module operand_select import rv_decode_pkg::*; (
    input  wire                 g_clk,
    input  wire                 g_resetn,
    input  wire                 accept_i,      // Instruction taken this cycle
    input  wire                 cf_req_i,
    input  wire                 cf_ack_i,
    input  wire [`RV_XLEN-1:0]  cf_target_i,
    input  wire [`RV_XLEN-1:0]  rs1_rdata_i,
    input  wire [`RV_XLEN-1:0]  rs2_rdata_i,
    input  wire [`RV_XLEN-1:0]  imm_i,
    input  wire [`RV_XLEN-1:0]  imm_pc_i,
    input  opr_src_t            opr_src_i,
    input  wire                 trap_i,        // Zero all operands
    input  wire [`RV_REG_W-1:0] rd_i,
    input  fu_e                 fu_i,
    input  uop_e                uop_i,
    output issue_t              issue_o
);

    logic [`RV_XLEN-1:0] pc_q;
    logic [`RV_XLEN-1:0] pc_plus_imm;
    logic [`RV_XLEN-1:0] opr_a;
    logic [`RV_XLEN-1:0] opr_b;
    logic [`RV_XLEN-1:0] opr_c;

    // ---------------------------------------------------------------------------
    // Program counter
    // ---------------------------------------------------------------------------
    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            pc_q <= `RV_PC_RESET;
        end else if (cf_req_i && cf_ack_i) begin
            pc_q <= cf_target_i;                       // Redirect beats step
        end else if (accept_i) begin
            pc_q <= pc_q + `RV_XLEN'(`RV_PC_STEP);
        end
    end

    assign pc_plus_imm = pc_q + imm_pc_i;              // Branch / jump target, AUIPC sum

    // ---------------------------------------------------------------------------
    // Operand muxes
    // ---------------------------------------------------------------------------
    always_comb begin
        case (opr_src_i.opra)
            A_RS1:   opr_a = rs1_rdata_i;
            A_PCIMM: opr_a = pc_plus_imm;
            default: opr_a = '0;
        endcase
        case (opr_src_i.oprb)
            B_RS2:   opr_b = rs2_rdata_i;
            B_IMM:   opr_b = imm_i;
            default: opr_b = '0;
        endcase
        case (opr_src_i.oprc)
            C_RS2:   opr_c = rs2_rdata_i;
            C_PCIMM: opr_c = pc_plus_imm;
            default: opr_c = '0;
        endcase
        if (trap_i) begin
            opr_a = '0;
            opr_b = '0;
            opr_c = '0;
        end
    end

    assign issue_o = '{rd: rd_i, opr_a: opr_a, opr_b: opr_b, opr_c: opr_c,
                       uop: uop_i, fu: fu_i};

endmodule

`default_nettype wire

//--- verilog/stage_register.sv
// One-entry decode/execute pipeline register with valid/busy flow control
`timescale 1ns/10ps
`default_nettype none

module stage_register import rv_decode_pkg::*; (
    input  wire    g_clk,
    input  wire    g_resetn,
    input  wire    flush_i,     // Drop the held record
    input  wire    valid_i,
    input  issue_t issue_i,
    input  wire    busy_i,      // Downstream stalled
    output logic   busy_o,      // Stall upstream
    output logic   accept_o,    // Input record taken
    output logic   valid_o,
    output issue_t issue_o
);

    logic   valid_q;
    issue_t issue_q;

    // Free or draining this cycle means a new record can land
    assign busy_o   = valid_q && busy_i;
    assign accept_o = valid_i && !busy_o;
    assign valid_o  = valid_q;
    assign issue_o  = issue_q;

    always_ff @(posedge g_clk) begin
        if (!g_resetn || flush_i) begin
            valid_q <= 1'b0;                           // Flush wins over load
        end else if (!busy_o) begin
            valid_q <= valid_i;
        end
    end

    always_ff @(posedge g_clk) begin
        if (accept_o) begin
            issue_q <= issue_i;
        end
    end

endmodule

`default_nettype wire

//--- verilog/rv_decode_top.sv
// Decode stage top level joining classifier, immediates, operands and stage register
`timescale 1ns/10ps
`default_nettype none
`include "rv_decode_macros.svh"

module rv_decode_top import rv_decode_pkg::*; (
    input  wire                 g_clk,
    input  wire                 g_resetn,
    input  wire                 s1_valid_i,   // Fetch word valid
    output logic                s1_busy_o,    // Stall fetch
    input  wire [31:0]          s1_data_i,    // Instruction word
    input  wire                 s1_error_i,   // Fetch error on this word
    input  wire                 s1_flush_i,
    output logic [`RV_REG_W-1:0] rs1_addr_o,
    output logic [`RV_REG_W-1:0] rs2_addr_o,
    input  wire [`RV_XLEN-1:0]  rs1_rdata_i,
    input  wire [`RV_XLEN-1:0]  rs2_rdata_i,
    input  wire                 cf_req_i,     // Control flow change request
    input  wire                 cf_ack_i,
    input  wire [`RV_XLEN-1:0]  cf_target_i,
    output logic                s2_valid_o,
    input  wire                 s2_busy_i,    // Execute stage stalled
    output issue_t              s2_issue_o
);

    logic [`RV_REG_W-1:0] rd;
    fu_e                  fu;
    uop_e                 uop;
    imm_fmt_e             imm_fmt;
    opr_src_t             opr_src;
    logic                 trap;
    logic [`RV_XLEN-1:0]  imm;
    logic [`RV_XLEN-1:0]  imm_pc;
    issue_t               issue;
    logic                 accept;         // Fetch word taken this cycle

    instr_classifier instr_classifier_i (
        .instr_i       (s1_data_i),
        .fetch_error_i (s1_error_i),
        .rs1_addr_o    (rs1_addr_o),
        .rs2_addr_o    (rs2_addr_o),
        .rd_o          (rd),
        .fu_o          (fu),
        .uop_o         (uop),
        .imm_fmt_o     (imm_fmt),
        .opr_src_o     (opr_src),
        .trap_o        (trap)
    );

    imm_extract imm_extract_i (
        .instr_i   (s1_data_i),
        .imm_fmt_i (imm_fmt),
        .imm_o     (imm),
        .imm_pc_o  (imm_pc)
    );

    operand_select operand_select_i (
        .g_clk       (g_clk),
        .g_resetn    (g_resetn),
        .accept_i    (accept),
        .cf_req_i    (cf_req_i),
        .cf_ack_i    (cf_ack_i),
        .cf_target_i (cf_target_i),
        .rs1_rdata_i (rs1_rdata_i),
        .rs2_rdata_i (rs2_rdata_i),
        .imm_i       (imm),
        .imm_pc_i    (imm_pc),
        .opr_src_i   (opr_src),
        .trap_i      (trap),
        .rd_i        (rd),
        .fu_i        (fu),
        .uop_i       (uop),
        .issue_o     (issue)
    );

    stage_register stage_register_i (
        .g_clk    (g_clk),
        .g_resetn (g_resetn),
        .flush_i  (s1_flush_i),
        .valid_i  (s1_valid_i),
        .issue_i  (issue),
        .busy_i   (s2_busy_i),
        .busy_o   (s1_busy_o),
        .accept_o (accept),
        .valid_o  (s2_valid_o),
        .issue_o  (s2_issue_o)
    );

endmodule

`default_nettype wire

//--- verification/tb_rv_decode.sv
// Testbench for the RV32I decode stage, replaying vectors under random back-pressure
`timescale 1ns/10ps
`default_nettype none
`include "rv_decode_macros.svh"

module tb_rv_decode import rv_decode_pkg::*; ();

    localparam int COLS     = 11;   // Words per vector row
    localparam int MAX_ROWS = 40;

    logic                 g_clk;
    logic                 g_resetn;
    logic                 s1_valid_i, s1_busy_o, s1_error_i, s1_flush_i;
    logic [31:0]          s1_data_i;
    logic [`RV_REG_W-1:0] rs1_addr_o, rs2_addr_o;
    logic [`RV_XLEN-1:0]  rs1_rdata_i, rs2_rdata_i, cf_target_i;
    logic                 cf_req_i, cf_ack_i;
    logic                 s2_valid_o, s2_busy_i;
    issue_t               s2_issue_o;

    logic [31:0] vec [0:MAX_ROWS*COLS-1];
    int          num_rows;
    issue_t      exp_q[$];          // Records accepted but not yet consumed
    int          row_q[$];
    logic        hold_busy;         // Keeps a record pending for a flush
    logic [16:0] lfsr;
    logic        held_valid;
    issue_t      held_rec;

    rv_decode_top rv_decode_top_i (.*);

    initial begin
        g_clk = 1'b0;
        forever #5 g_clk = ~g_clk;
    end

    // ------------------------------------------------------------------------
    // Checks
    // ------------------------------------------------------------------------
    task automatic stop_run();
        $display("TEST FAILED");
        $fatal(1, "decode stage check failed");
    endtask

    task automatic check_fu(input fu_e got, input fu_e exp, input string what);
        if (got !== exp) begin
            $display("[FAIL] %0t: %s fu %s, expected %s", $time, what, got.name(), exp.name());
            stop_run();
        end
    endtask

    task automatic check_uop(input uop_e got, input uop_e exp, input string what);
        if (got !== exp) begin
            $display("[FAIL] %0t: %s uop %h, expected %h", $time, what, got, exp);
            stop_run();
        end
    endtask

    task automatic check_rd(input logic [`RV_REG_W-1:0] got, input logic [`RV_REG_W-1:0] exp,
                            input string what);
        if (got !== exp) begin
            $display("[FAIL] %0t: %s rd %0d, expected %0d", $time, what, got, exp);
            stop_run();
        end
    endtask

    task automatic check_reg_addr(input logic [`RV_REG_W-1:0] got,
                                  input logic [`RV_REG_W-1:0] exp, input string what);
        if (got !== exp) begin
            $display("[FAIL] %0t: %s address %0d, expected %0d", $time, what, got, exp);
            stop_run();
        end
    endtask

    task automatic check_operand(input logic [`RV_XLEN-1:0] got, input logic [`RV_XLEN-1:0] exp,
                                 input string what);
        if (got !== exp) begin
            $display("[FAIL] %0t: %s is %h, expected %h", $time, what, got, exp);
            stop_run();
        end
    endtask

    task automatic compare_record(input issue_t got, input issue_t exp, input string what);
        check_fu(got.fu, exp.fu, what);
        check_uop(got.uop, exp.uop, what);
        check_rd(got.rd, exp.rd, what);
        check_operand(got.opr_a, exp.opr_a, {what, " operand A"});
        check_operand(got.opr_b, exp.opr_b, {what, " operand B"});
        check_operand(got.opr_c, exp.opr_c, {what, " operand C"});
    endtask

    function automatic logic [31:0] field(input int row, input int col);
        return vec[row*COLS+col];
    endfunction

    // x^17 + x^14 + 1
    function automatic logic [16:0] lfsr_step(input logic [16:0] s);
        return {s[15:0], s[16] ^ s[13]};
    endfunction

    // ------------------------------------------------------------------------
    // Back-pressure and output monitor
    // ------------------------------------------------------------------------
    always @(posedge g_clk) begin
        if (!g_resetn) begin
            s2_busy_i <= 1'b0;
        end else if (hold_busy) begin
            s2_busy_i <= 1'b1;
        end else begin
            lfsr = lfsr_step(lfsr);
            s2_busy_i <= lfsr[0];
        end
    end

    always @(negedge g_clk) begin
        if (g_resetn) begin
            if (held_valid && s2_valid_o) begin
                compare_record(s2_issue_o, held_rec, "Held record");   // Must not move
            end
            held_valid = s2_valid_o && s2_busy_i;
            held_rec   = s2_issue_o;
            if (s2_valid_o && !s2_busy_i) begin
                if (exp_q.size() == 0) begin
                    $display("Output record appeared with nothing expected at %0t", $time);
                    stop_run();
                end
                compare_record(s2_issue_o, exp_q.pop_front(),
                               $sformatf("Row %0d", row_q.pop_front()));
            end
        end
    end

    // ------------------------------------------------------------------------
    // Stimulus, each task starts and ends just after a rising edge
    // ------------------------------------------------------------------------
    task automatic drive_instr(input int r);
        issue_t      exp;
        logic        acc;
        logic [31:0] instr;
        instr = field(r, 1);
        s1_valid_i  <= 1'b1;
        s1_data_i   <= instr;
        s1_error_i  <= 1'(field(r, 2));
        rs1_rdata_i <= field(r, 3);
        rs2_rdata_i <= field(r, 4);
        exp.fu    = fu_e'(2'(field(r, 5)));
        exp.uop   = uop_e'(5'(field(r, 6)));
        exp.rd    = `RV_REG_W'(field(r, 7));
        exp.opr_a = field(r, 8);
        exp.opr_b = field(r, 9);
        exp.opr_c = field(r, 10);
        acc = 1'b0;
        while (!acc) begin
            @(negedge g_clk);
            // Register file addresses are the rs1 and rs2 fields of the word
            check_reg_addr(rs1_addr_o, instr[19:15], $sformatf("Row %0d rs1", r));
            check_reg_addr(rs2_addr_o, instr[24:20], $sformatf("Row %0d rs2", r));
            acc = !s1_busy_o;
            if (acc) begin
                exp_q.push_back(exp);
                row_q.push_back(r);
                if (field(r + 1, 0) == 32'h2) begin
                    hold_busy = 1'b1;
                end
            end
            @(posedge g_clk);
        end
    endtask

    task automatic do_redirect(input int r);
        s1_valid_i  <= 1'b0;
        cf_req_i    <= 1'b1;
        cf_ack_i    <= 1'b1;
        cf_target_i <= field(r, 1);
        @(posedge g_clk);
        cf_req_i <= 1'b0;
        cf_ack_i <= 1'b0;
    endtask

    task automatic do_flush();
        s1_valid_i <= 1'b0;
        @(negedge g_clk);
        if (!s2_valid_o) begin
            $display("No record was pending when the flush was due at %0t", $time);
            stop_run();
        end
        // Pending record is checked here since it never drains
        compare_record(s2_issue_o, exp_q[$], $sformatf("Row %0d", row_q[$]));
        @(posedge g_clk);
        s1_flush_i <= 1'b1;
        @(posedge g_clk);
        s1_flush_i <= 1'b0;
        @(negedge g_clk);
        if (s2_valid_o) begin
            $display("[FAIL] %0t: s2_valid_o still high after flush", $time);
            stop_run();
        end
        void'(exp_q.pop_back());    // Flushed record never arrives
        void'(row_q.pop_back());
        hold_busy = 1'b0;
        @(posedge g_clk);
    endtask

    initial begin
        g_resetn    = 1'b0;
        s1_valid_i  = 1'b0;
        s1_data_i   = '0;
        s1_error_i  = 1'b0;
        s1_flush_i  = 1'b0;
        rs1_rdata_i = '0;
        rs2_rdata_i = '0;
        cf_req_i    = 1'b0;
        cf_ack_i    = 1'b0;
        cf_target_i = '0;
        s2_busy_i   = 1'b0;
        hold_busy   = 1'b0;
        held_valid  = 1'b0;
        lfsr        = 17'd95299;
        num_rows    = 0;
        for (int i = 0; i < MAX_ROWS*COLS; i++) begin
            vec[i] = 32'hf;         // End marker in every kind column
        end
        $readmemh("verification/decode_input.txt", vec);
        while (num_rows < MAX_ROWS - 1 && field(num_rows, 0) != 32'hf) begin
            num_rows++;
        end

        repeat (16) @(posedge g_clk);
        g_resetn <= 1'b1;
        @(negedge g_clk);
        if (s2_valid_o || s1_busy_o) begin
            $display("[FAIL] %0t: valid or busy high after reset", $time);
            stop_run();
        end
        @(posedge g_clk);
        for (int r = 0; r < num_rows; r++) begin
            case (field(r, 0))
                32'h0:   drive_instr(r);
                32'h1:   do_redirect(r);
                default: do_flush();
            endcase
        end
        s1_valid_i <= 1'b0;
        while (exp_q.size() != 0) begin
            @(negedge g_clk);
        end
        @(posedge g_clk);
        $display("TEST PASSED");
        $finish;
    end

    // Watchdog
    initial begin
        int cycles;
        #1;
        cycles = num_rows * 20 + 16;
        #(cycles * 10);
        $display("Timeout after %0d cycles with %0d records outstanding", cycles, exp_q.size());
        stop_run();
    end

endmodule

`default_nettype wire

//--- verification/decode_input.txt
// kind(0 instr,1 redirect,2 flush,f end) instr/target err rs1 rs2
// then expected fu uop rd opr_a opr_b opr_c
0 12345297 0 11111111 22222222 1 00 05 92345000 00000000 00000000
0 002081b3 0 00000005 00000007 1 00 03 00000005 00000007 00000000
0 40208233 0 0000000a 00000003 1 01 04 0000000a 00000003 00000000
0 4020d333 0 80000000 00000004 1 09 06 80000000 00000004 00000000
0 fff08393 0 00000010 00000000 1 00 07 00000010 ffffffff 00000000
0 4030d413 0 f0000000 00000000 1 09 08 f0000000 00000403 00000000
0 0f00f493 0 12345678 00000000 1 02 09 12345678 000000f0 00000000
0 abcde537 0 55555555 66666666 1 03 0a 00000000 abcde000 00000000
0 ffc12583 0 00001000 00000000 2 1c 0b 00001000 fffffffc 00000000
0 0051c603 0 00002000 00000000 2 19 0c 00002000 00000005 00000000
0 00532423 0 00003000 deadbeef 2 1f 00 00003000 00000008 deadbeef
0 fe740fa3 0 00004000 000000ab 2 1d 00 00004000 ffffffff 000000ab
0 00208863 0 00000001 00000002 3 10 00 00000001 00000002 80000040
0 fe419ce3 0 00000003 00000004 3 11 00 00000003 00000004 8000002c
0 001000ef 0 77777777 88888888 3 16 01 00000000 00000000 80000838
0 00c280e7 0 00005000 00000000 3 17 01 00005000 0000000c 00000000
1 00001000 0 00000000 00000000 0 00 00 00000000 00000000 00000000
0 00001117 0 00000000 00000000 1 00 02 00002000 00000000 00000000
0 0020d463 0 0000000a 0000000b 3 13 00 0000000a 0000000b 0000100c
0 ffffffff 0 12121212 34343434 0 00 02 00000000 00000000 00000000
0 00004501 0 12121212 34343434 0 00 02 00000000 00000000 00000000
0 002081b3 1 00000005 00000007 0 00 01 00000000 00000000 00000000
2 00000000 0 00000000 00000000 0 00 00 00000000 00000000 00000000
0 00000073 0 00000000 00000000 0 00 02 00000000 00000000 00000000
0 00f766b3 0 0000f0f0 00000f0f 1 03 0d 0000f0f0 00000f0f 00000000
f 00000000 0 00000000 00000000 0 00 00 00000000 00000000 00000000

//--- project.f
+incdir+verilog
verilog/rv_decode_pkg.sv
verilog/instr_classifier.sv
verilog/imm_extract.sv
verilog/operand_select.sv
verilog/stage_register.sv
verilog/rv_decode_top.sv
verification/tb_rv_decode.sv

//--- run.sh
#!/bin/sh
# Build and run the decode stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module tb_rv_decode -f project.f -o sim_rv_decode
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/sim_rv_decode > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "TEST PASSED" sim.log; then
    exit 0
fi
exit 1
